// File: rtl/miner_pkg.sv
package miner_pkg;

	// the block header is 352 bits wide and arrives one byte at a time
	localparam int STATE_W    = 352;
	localparam int CHUNK_W    = 8;
	localparam int NUM_CHUNKS = STATE_W / CHUNK_W;

	// nonce, score and target all share the 32-bit word width
	localparam int WORD_W    = 32;
	localparam int NUM_WORDS = STATE_W / WORD_W;

	localparam int REPEAT_W   = 8;
	localparam int CHUNK_IX_W = 6;

	// index of the chunk that completes a header
	localparam logic [CHUNK_IX_W-1:0] LAST_CHUNK_IX = CHUNK_IX_W'(NUM_CHUNKS - 1);

	// configuration values loaded at reset
	localparam logic [REPEAT_W-1:0] DEF_REPEATS      = REPEAT_W'(16);
	localparam logic [WORD_W-1:0]   DEF_NONCE_BASE   = '0;
	localparam logic [WORD_W-1:0]   DEF_NONCE_STRIDE = WORD_W'(1);
	// an all-ones target lets nearly every score through
	localparam logic [WORD_W-1:0]   DEF_TARGET       = '1;

	typedef enum logic [0:0] {
		COLLECT   = 1'b0,
		BROADCAST = 1'b1
	} storage_state_e;

	typedef enum logic [1:0] {
		CFG_REPEATS      = 2'd0,
		CFG_NONCE_BASE   = 2'd1,
		CFG_NONCE_STRIDE = 2'd2,
		CFG_TARGET       = 2'd3
	} cfg_addr_e;

endpackage

// File: rtl/block_storage.sv
module block_storage (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           write_valid_i,
	input  logic [miner_pkg::CHUNK_W-1:0]  write_data_i,
	output logic                           write_ready_o,
	input  logic [miner_pkg::REPEAT_W-1:0] repeats_i,
	output logic                           bcast_valid_o,
	output logic                           bcast_first_o,
	output logic [miner_pkg::STATE_W-1:0]  bcast_state_o
);

	// controller state decides whether bytes are taken or the header is broadcast
	miner_pkg::storage_state_e state_q;

	// position of the next byte within the header
	logic [miner_pkg::CHUNK_IX_W-1:0] chunk_ix_q;

	// remaining broadcast cycles, loaded from the repeat count at end of collection
	logic [miner_pkg::REPEAT_W-1:0] bcast_cnt_q;

	// assembled header, held steady for the whole broadcast
	logic [miner_pkg::STATE_W-1:0] header_q;

	logic chunk_accept;
	logic last_chunk;
	logic last_bcast;

	// the source may only hand over bytes while we are collecting
	assign write_ready_o = (state_q == miner_pkg::COLLECT);

	// a byte moves on any edge where valid and ready are both high
	assign chunk_accept = write_valid_i && write_ready_o;

	// this byte completes the header
	assign last_chunk = (chunk_ix_q == miner_pkg::LAST_CHUNK_IX);

	// the counter reaching one means this is the final broadcast cycle of the state
	assign last_bcast = (bcast_cnt_q == miner_pkg::REPEAT_W'(1));

	// controller and counters
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q     <= miner_pkg::COLLECT;
			chunk_ix_q  <= '0;
			bcast_cnt_q <= '0;
		end else begin
			case (state_q)
				miner_pkg::COLLECT: begin
					if (chunk_accept) begin
						if (last_chunk) begin
							// header complete, so sample the repeat count once here
							state_q     <= miner_pkg::BROADCAST;
							chunk_ix_q  <= '0;
							bcast_cnt_q <= repeats_i;
						end else begin
							chunk_ix_q <= chunk_ix_q + 1'b1;
						end
					end
				end
				miner_pkg::BROADCAST: begin
					// one broadcast per cycle with no stall on the output side
					bcast_cnt_q <= bcast_cnt_q - 1'b1;
					if (last_bcast) begin
						state_q <= miner_pkg::COLLECT;
					end
				end
				default: begin
					state_q <= miner_pkg::COLLECT;
				end
			endcase
		end
	end

	// bytes shift in from the bottom, so chunk 0 ends up in bits 351 to 344
	// after all 44 have arrived
	always_ff @(posedge clk_i) begin
		if (chunk_accept) begin
			header_q <= {header_q[miner_pkg::STATE_W-miner_pkg::CHUNK_W-1:0], write_data_i};
		end
	end

	// the broadcast flags trail the state by one register stage, which keeps
	// them glitch free and gives R valid cycles for R cycles spent in BROADCAST
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bcast_valid_o <= 1'b0;
			bcast_first_o <= 1'b0;
		end else begin
			bcast_valid_o <= (state_q == miner_pkg::BROADCAST);
			// the first broadcast is the one with no broadcast just before it.
			// two blocks are always at least 44 idle cycles apart, so this is exact
			bcast_first_o <= (state_q == miner_pkg::BROADCAST) && !bcast_valid_o;
		end
	end

	// header bytes only start shifting again once a chunk is accepted in COLLECT,
	// which is at least one edge after the last broadcast flag has been sampled
	assign bcast_state_o = header_q;

endmodule

// File: rtl/miner_cfg_regs.sv
module miner_cfg_regs (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           cfg_we_i,
	input  miner_pkg::cfg_addr_e           cfg_addr_i,
	input  logic [miner_pkg::WORD_W-1:0]   cfg_wdata_i,
	output logic [miner_pkg::REPEAT_W-1:0] repeats_o,
	output logic [miner_pkg::WORD_W-1:0]   nonce_base_o,
	output logic [miner_pkg::WORD_W-1:0]   nonce_stride_o,
	output logic [miner_pkg::WORD_W-1:0]   target_o
);

	// low byte of the write data as a candidate repeat count
	logic [miner_pkg::REPEAT_W-1:0] repeats_wr;

	// a repeat count of zero would stall the storage controller for 256 cycles
	// with counter wrap, so it is stored as one instead
	always_comb begin
		repeats_wr = cfg_wdata_i[miner_pkg::REPEAT_W-1:0];
		if (repeats_wr == '0) begin
			repeats_wr = miner_pkg::REPEAT_W'(1);
		end
	end

	// the registers drive their outputs directly with no read path
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			repeats_o      <= miner_pkg::DEF_REPEATS;
			nonce_base_o   <= miner_pkg::DEF_NONCE_BASE;
			nonce_stride_o <= miner_pkg::DEF_NONCE_STRIDE;
			target_o       <= miner_pkg::DEF_TARGET;
		end else if (cfg_we_i) begin
			// single-cycle strobe, the new value is live from the next cycle
			case (cfg_addr_i)
				miner_pkg::CFG_REPEATS: begin
					repeats_o <= repeats_wr;
				end
				miner_pkg::CFG_NONCE_BASE: begin
					nonce_base_o <= cfg_wdata_i;
				end
				miner_pkg::CFG_NONCE_STRIDE: begin
					nonce_stride_o <= cfg_wdata_i;
				end
				miner_pkg::CFG_TARGET: begin
					target_o <= cfg_wdata_i;
				end
				default: begin
					// every two-bit address is decoded above
					repeats_o <= repeats_o;
				end
			endcase
		end
	end

endmodule

// File: rtl/nonce_dispatch.sv
module nonce_dispatch (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          bcast_valid_i,
	input  logic                          bcast_first_i,
	input  logic [miner_pkg::STATE_W-1:0] bcast_state_i,
	input  logic [miner_pkg::WORD_W-1:0]  nonce_base_i,
	input  logic [miner_pkg::WORD_W-1:0]  nonce_stride_i,
	output logic                          disp_valid_o,
	output logic                          disp_first_o,
	output logic [miner_pkg::WORD_W-1:0]  disp_nonce_o,
	output logic [miner_pkg::STATE_W-1:0] disp_state_o
);

	// nonce handed to the current broadcast
	logic [miner_pkg::WORD_W-1:0] nonce_next;

	// a new block restarts at the base, later broadcasts step by the stride.
	// the add wraps naturally at 2 to the 32
	always_comb begin
		if (bcast_first_i) begin
			nonce_next = nonce_base_i;
		end else begin
			nonce_next = disp_nonce_o + nonce_stride_i;
		end
	end

	// flags are control state and are cleared at reset
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			disp_valid_o <= 1'b0;
			disp_first_o <= 1'b0;
		end else begin
			disp_valid_o <= bcast_valid_i;
			disp_first_o <= bcast_valid_i && bcast_first_i;
		end
	end

	// the running nonce only advances on a broadcast, so the last value issued
	// stays available as the starting point of the next step
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			disp_nonce_o <= miner_pkg::DEF_NONCE_BASE;
		end else if (bcast_valid_i) begin
			disp_nonce_o <= nonce_next;
		end
	end

	// state travels next to its nonce with no reset
	always_ff @(posedge clk_i) begin
		if (bcast_valid_i) begin
			disp_state_o <= bcast_state_i;
		end
	end

endmodule

// File: rtl/share_filter.sv
module share_filter (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          disp_valid_i,
	input  logic                          disp_first_i,
	input  logic [miner_pkg::WORD_W-1:0]  disp_nonce_i,
	input  logic [miner_pkg::STATE_W-1:0] disp_state_i,
	input  logic [miner_pkg::WORD_W-1:0]  target_i,
	output logic                          share_valid_o,
	output logic                          share_first_o,
	output logic [miner_pkg::WORD_W-1:0]  share_nonce_o,
	output logic [miner_pkg::WORD_W-1:0]  share_score_o,
	output logic                          share_hit_o
);

	// score of the item at the input, before the output register
	logic [miner_pkg::WORD_W-1:0] score;
	logic                         hit;

	// the score is a plain XOR fold standing in for the real double hash.
	// all eleven header words are folded in along with the nonce
	always_comb begin
		score = disp_nonce_i;
		for (int i = 0; i < miner_pkg::NUM_WORDS; i++) begin
			score = score ^ disp_state_i[i*miner_pkg::WORD_W +: miner_pkg::WORD_W];
		end
	end

	// a share is a valid item whose score lies strictly below the target.
	// a score equal to the target is not a hit
	assign hit = disp_valid_i && (score < target_i);

	// flags carry reset so no stale hit shows after reset
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			share_valid_o <= 1'b0;
			share_first_o <= 1'b0;
			share_hit_o   <= 1'b0;
		end else begin
			share_valid_o <= disp_valid_i;
			share_first_o <= disp_valid_i && disp_first_i;
			share_hit_o   <= hit;
		end
	end

	// nonce and score are payload and only meaningful under share_valid_o
	always_ff @(posedge clk_i) begin
		if (disp_valid_i) begin
			share_nonce_o <= disp_nonce_i;
			share_score_o <= score;
		end
	end

endmodule

// File: rtl/miner_front_top.sv
module miner_front_top (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          write_valid_i,
	input  logic [miner_pkg::CHUNK_W-1:0] write_data_i,
	output logic                          write_ready_o,
	input  logic                          cfg_we_i,
	input  miner_pkg::cfg_addr_e          cfg_addr_i,
	input  logic [miner_pkg::WORD_W-1:0]  cfg_wdata_i,
	output logic                          share_valid_o,
	output logic                          share_first_o,
	output logic [miner_pkg::WORD_W-1:0]  share_nonce_o,
	output logic [miner_pkg::WORD_W-1:0]  share_score_o,
	output logic                          share_hit_o
);

	// configuration values fanned out to the pipeline stages
	logic [miner_pkg::REPEAT_W-1:0] repeats;
	logic [miner_pkg::WORD_W-1:0]   nonce_base;
	logic [miner_pkg::WORD_W-1:0]   nonce_stride;
	logic [miner_pkg::WORD_W-1:0]   target;

	// storage to dispatcher
	logic                          bcast_valid;
	logic                          bcast_first;
	logic [miner_pkg::STATE_W-1:0] bcast_state;

	// dispatcher to share filter
	logic                          disp_valid;
	logic                          disp_first;
	logic [miner_pkg::WORD_W-1:0]  disp_nonce;
	logic [miner_pkg::STATE_W-1:0] disp_state;

	miner_cfg_regs u_cfg_regs (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.cfg_we_i       (cfg_we_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_wdata_i    (cfg_wdata_i),
		.repeats_o      (repeats),
		.nonce_base_o   (nonce_base),
		.nonce_stride_o (nonce_stride),
		.target_o       (target)
	);

	block_storage u_block_storage (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.write_valid_i (write_valid_i),
		.write_data_i  (write_data_i),
		.write_ready_o (write_ready_o),
		.repeats_i     (repeats),
		.bcast_valid_o (bcast_valid),
		.bcast_first_o (bcast_first),
		.bcast_state_o (bcast_state)
	);

	// one register stage from broadcast to dispatch
	nonce_dispatch u_nonce_dispatch (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.bcast_valid_i  (bcast_valid),
		.bcast_first_i  (bcast_first),
		.bcast_state_i  (bcast_state),
		.nonce_base_i   (nonce_base),
		.nonce_stride_i (nonce_stride),
		.disp_valid_o   (disp_valid),
		.disp_first_o   (disp_first),
		.disp_nonce_o   (disp_nonce),
		.disp_state_o   (disp_state)
	);

	// and one more stage to the scored result
	share_filter u_share_filter (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.disp_valid_i  (disp_valid),
		.disp_first_i  (disp_first),
		.disp_nonce_i  (disp_nonce),
		.disp_state_i  (disp_state),
		.target_i      (target),
		.share_valid_o (share_valid_o),
		.share_first_o (share_first_o),
		.share_nonce_o (share_nonce_o),
		.share_score_o (share_score_o),
		.share_hit_o   (share_hit_o)
	);

endmodule

// File: verification/tb_miner_front.sv
module tb_miner_front;

	timeunit 1ns;
	timeprecision 100ps;

	// largest idle gap in cycles that the source inserts before a chunk
	localparam int GAP_MAX = 4;
	// number of configuration writes made over the whole run
	localparam int NUM_CFG_WRITES = 9;

	logic                          clk_i;
	logic                          rst_n_i;
	logic                          write_valid_i;
	logic [miner_pkg::CHUNK_W-1:0] write_data_i;
	logic                          write_ready_o;
	logic                          cfg_we_i;
	miner_pkg::cfg_addr_e          cfg_addr_i;
	logic [miner_pkg::WORD_W-1:0]  cfg_wdata_i;
	logic                          share_valid_o;
	logic                          share_first_o;
	logic [miner_pkg::WORD_W-1:0]  share_nonce_o;
	logic [miner_pkg::WORD_W-1:0]  share_score_o;
	logic                          share_hit_o;

	integer seed;
	int     cycle_cnt;
	int     timeout_cycles;

	// model of the configuration registers as the testbench has written them
	logic [miner_pkg::REPEAT_W-1:0] cur_repeats;
	logic [miner_pkg::WORD_W-1:0]   cur_base;
	logic [miner_pkg::WORD_W-1:0]   cur_stride;
	logic [miner_pkg::WORD_W-1:0]   cur_target;

	// expected results as {first, hit, nonce, score}, oldest first
	logic [65:0] exp_q[$];
	// cycle number at which share_valid_o should rise for each block
	int          rise_q[$];

	miner_front_top uut (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.write_valid_i (write_valid_i),
		.write_data_i  (write_data_i),
		.write_ready_o (write_ready_o),
		.cfg_we_i      (cfg_we_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_wdata_i   (cfg_wdata_i),
		.share_valid_o (share_valid_o),
		.share_first_o (share_first_o),
		.share_nonce_o (share_nonce_o),
		.share_score_o (share_score_o),
		.share_hit_o   (share_hit_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#4 clk_i = ~clk_i;
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	// score is the nonce XOR all eleven header words, a hit is a score strictly below target
	function automatic logic [miner_pkg::WORD_W:0] expected_score(
		input logic [miner_pkg::STATE_W-1:0] hdr,
		input logic [miner_pkg::WORD_W-1:0]  nonce,
		input logic [miner_pkg::WORD_W-1:0]  target
	);
		logic [miner_pkg::WORD_W-1:0] s;
		s = nonce;
		for (int w = 0; w < miner_pkg::NUM_WORDS; w++) begin
			s = s ^ hdr[w*miner_pkg::WORD_W +: miner_pkg::WORD_W];
		end
		return {(s < target), s};
	endfunction

	// worst case cycles for one block with r broadcasts and gaps up to g per chunk
	function automatic int block_budget(input int r, input int g);
		return miner_pkg::NUM_CHUNKS + r + miner_pkg::NUM_CHUNKS * g + 10;
	endfunction

	// cycle counter doubles as the run limit
	initial begin
		cycle_cnt = 0;
		timeout_cycles = 60 + block_budget(16, 0) + 2 * block_budget(16, GAP_MAX)
			+ block_budget(5, GAP_MAX) + 2 * block_budget(1, GAP_MAX)
			+ 4 * block_budget(8, GAP_MAX) + 3 * block_budget(6, 0)
			+ 2 * NUM_CFG_WRITES;
		forever begin
			@(posedge clk_i);
			cycle_cnt++;
			if (cycle_cnt > timeout_cycles) begin
				abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
					timeout_cycles));
			end
		end
	end

	// one-cycle write strobe, launched on a falling edge
	task automatic write_cfg(input miner_pkg::cfg_addr_e addr,
		input logic [miner_pkg::WORD_W-1:0] data);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = data;
		@(negedge clk_i);
		cfg_we_i = 1'b0;
		case (addr)
			miner_pkg::CFG_REPEATS: begin
				// only the low byte counts, and zero means one
				cur_repeats = (data[7:0] == 8'd0) ? 8'd1 : data[7:0];
			end
			miner_pkg::CFG_NONCE_BASE: begin
				cur_base = data;
			end
			miner_pkg::CFG_NONCE_STRIDE: begin
				cur_stride = data;
			end
			default: begin
				cur_target = data;
			end
		endcase
	endtask

	// queues every broadcast of a finished header along with its nonce
	task automatic queue_results(input logic [miner_pkg::STATE_W-1:0] hdr,
		input int accept_cycle);
		logic [miner_pkg::WORD_W-1:0] nonce;
		logic [miner_pkg::WORD_W:0]   res;
		nonce = cur_base;
		for (int k = 0; k < int'(cur_repeats); k++) begin
			// the first broadcast starts at the base and later ones step by the stride
			if (k > 0) begin
				nonce = nonce + cur_stride;
			end
			res = expected_score(hdr, nonce, cur_target);
			exp_q.push_back({(k == 0), res[miner_pkg::WORD_W], nonce,
				res[miner_pkg::WORD_W-1:0]});
		end
		// results leave the pipeline three cycles after the accepting edge
		rise_q.push_back(accept_cycle + 3);
	endtask

	// sends one random header, chunk 0 first, with random idle cycles up to max_gap
	task automatic send_block(input int max_gap);
		logic [miner_pkg::STATE_W-1:0] hdr;
		logic [miner_pkg::CHUNK_W-1:0] b;
		int                            gap;
		hdr = '0;
		for (int i = 0; i < miner_pkg::NUM_CHUNKS; i++) begin
			b = miner_pkg::CHUNK_W'($random(seed));
			// chunk 0 is the most significant byte of the header
			hdr[miner_pkg::STATE_W-1-miner_pkg::CHUNK_W*i -: miner_pkg::CHUNK_W] = b;
			gap = $unsigned($random(seed)) % (max_gap + 1);
			repeat (gap) begin
				// junk on the data lines while idle must never be taken
				write_valid_i = 1'b0;
				write_data_i  = miner_pkg::CHUNK_W'($random(seed));
				@(negedge clk_i);
			end
			write_valid_i = 1'b1;
			write_data_i  = b;
			// hold the chunk until ready is seen, ready only changes on rising edges
			while (!write_ready_o) begin
				@(negedge clk_i);
			end
			if (i == miner_pkg::NUM_CHUNKS - 1) begin
				// the next rising edge takes the last chunk
				queue_results(hdr, cycle_cnt + 1);
			end
			@(negedge clk_i);
		end
		write_valid_i = 1'b0;
		assert (!write_ready_o) else begin
			abort_run("write_ready_o stayed high after the last chunk of a block");
		end
	endtask

	// waits until every queued result has come out, plus a little idle time
	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(negedge clk_i);
		end
		repeat (3) @(negedge clk_i);
	endtask

	// comparison process, sampling outputs mid-cycle where they are stable
	initial begin
		logic [65:0] exp;
		logic        prev_valid;
		int          exp_rise;
		prev_valid = 1'b0;
		forever begin
			@(negedge clk_i);
			if (share_valid_o && !prev_valid) begin
				assert (rise_q.size() > 0) else begin
					abort_run("share_valid_o rose with no block sent");
				end
				exp_rise = rise_q.pop_front();
				assert (cycle_cnt == exp_rise) else begin
					abort_run($sformatf(
						"ERROR %0d ns: share_valid_o rise cycle expected %0d actual %0d",
						$time, exp_rise, cycle_cnt));
				end
			end
			if (share_valid_o) begin
				assert (exp_q.size() > 0) else begin
					abort_run("share_valid_o was high but no result was expected");
				end
				exp = exp_q.pop_front();
				assert (share_first_o === exp[65]) else begin
					abort_run($sformatf("ERROR %0d ns: share_first_o expected %0b actual %0b",
						$time, exp[65], share_first_o));
				end
				assert (share_nonce_o === exp[63:32]) else begin
					abort_run($sformatf("ERROR %0d ns: share_nonce_o expected %08h actual %08h",
						$time, exp[63:32], share_nonce_o));
				end
				assert (share_score_o === exp[31:0]) else begin
					abort_run($sformatf("ERROR %0d ns: share_score_o expected %08h actual %08h",
						$time, exp[31:0], share_score_o));
				end
				assert (share_hit_o === exp[64]) else begin
					abort_run($sformatf("ERROR %0d ns: share_hit_o expected %0b actual %0b",
						$time, exp[64], share_hit_o));
				end
			end
			prev_valid = share_valid_o;
		end
	end

	// stimulus
	initial begin
		seed          = 32'h7793;
		rst_n_i       = 1'b0;
		write_valid_i = 1'b0;
		write_data_i  = '0;
		cfg_we_i      = 1'b0;
		cfg_addr_i    = miner_pkg::CFG_REPEATS;
		cfg_wdata_i   = '0;
		cur_repeats   = 8'd16;
		cur_base      = 32'h0000_0000;
		cur_stride    = 32'h0000_0001;
		cur_target    = 32'hFFFF_FFFF;
		repeat (5) @(negedge clk_i);
		assert (write_ready_o === 1'b1) else begin
			abort_run($sformatf("ERROR %0d ns: write_ready_o expected 1 actual %0b",
				$time, write_ready_o));
		end
		assert (share_valid_o === 1'b0) else begin
			abort_run($sformatf("ERROR %0d ns: share_valid_o expected 0 actual %0b",
				$time, share_valid_o));
		end
		assert (share_first_o === 1'b0) else begin
			abort_run($sformatf("ERROR %0d ns: share_first_o expected 0 actual %0b",
				$time, share_first_o));
		end
		assert (share_hit_o === 1'b0) else begin
			abort_run($sformatf("ERROR %0d ns: share_hit_o expected 0 actual %0b",
				$time, share_hit_o));
		end
		rst_n_i = 1'b1;
		@(negedge clk_i);

		// default configuration, one block without gaps gives sixteen results
		send_block(0);
		wait_drained();

		// idle gaps on the chunk stream
		send_block(GAP_MAX);
		send_block(GAP_MAX);
		wait_drained();

		// five repeats with a base close to the top so the nonce wraps
		write_cfg(miner_pkg::CFG_REPEATS, 32'd5);
		write_cfg(miner_pkg::CFG_NONCE_BASE, 32'hFFFF_FFF0);
		write_cfg(miner_pkg::CFG_NONCE_STRIDE, 32'd7);
		send_block(GAP_MAX);
		wait_drained();
		// low byte zero, so one result per block
		write_cfg(miner_pkg::CFG_REPEATS, 32'h0000_0100);
		send_block(GAP_MAX);
		send_block(GAP_MAX);
		wait_drained();

		// mid-range target so roughly half the scores hit
		write_cfg(miner_pkg::CFG_TARGET, 32'h8000_0000);
		write_cfg(miner_pkg::CFG_REPEATS, 32'd8);
		repeat (4) send_block(GAP_MAX);
		wait_drained();

		// back to back blocks, the source waits out each broadcast with valid high
		write_cfg(miner_pkg::CFG_REPEATS, 32'd6);
		write_cfg(miner_pkg::CFG_NONCE_BASE, 32'd100);
		write_cfg(miner_pkg::CFG_NONCE_STRIDE, 32'd3);
		repeat (3) send_block(0);
		wait_drained();

		repeat (10) @(negedge clk_i);
		assert (exp_q.size() == 0 && rise_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run("some expected results never came out");
		end
	end

endmodule

// File: build.f
rtl/miner_pkg.sv
rtl/block_storage.sv
rtl/miner_cfg_regs.sv
rtl/nonce_dispatch.sv
rtl/share_filter.sv
rtl/miner_front_top.sv
verification/tb_miner_front.sv
